/* Makefile */
TOP = dataCacheTb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	obj_dir/V$(TOP) +verilator+error+limit+100 | tee run.log
	@grep -q "^ALL CHECKS PASSED$$" run.log || (echo "simulation failed, see run.log"; exit 1)

obj_dir/V$(TOP): list.f $(wildcard hw/*.sv tests/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir run.log

/* hw/cacheCtrl.sv */
`timescale 1ns/1ps

module cacheCtrl (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  dcachePkg::cacheReq_t                       req_i,
  input  logic                                       hit_i,
  input  logic                                       hitWay_i,
  input  logic                                       victimDirty_i,
  input  logic [dcachePkg::TagWidth-1:0]             victimTag_i,
  input  logic                                       lastBeat_i,
  input  logic                                       memRdReady_i,
  input  logic                                       memWrReady_i,
  output logic                                       ready_o,
  output logic                                       done_o,
  output dcachePkg::lineAddr_t                       reqAddr_o,
  output logic [$clog2(dcachePkg::BeatsPerLine)-1:0] wordSel_o,
  output logic [$clog2(dcachePkg::MaskWidth)-1:0]    byteOff_o,
  output logic [dcachePkg::WordWidth-1:0]            storeData_o,
  output logic [dcachePkg::MaskWidth-1:0]            storeMask_o,
  output logic                                       storeEn_o,
  output logic                                       fillEn_o,
  output logic                                       way_o,
  output dcachePkg::memRdReq_t                       memRdReq_o,
  output logic [dcachePkg::AddrWidth-1:0]            memWrAddr_o,
  output logic                                       memWrValid_o,
  output logic                                       refillActive_o
);

  dcachePkg::cacheState_e stateQ;
  dcachePkg::cacheState_e stateD;
  dcachePkg::cacheReq_t   reqQ;
  logic [15:0]            lfsrQ;
  logic                   victimQ;
  logic                   accept;
  logic                   inLookup;

  assign accept   = (stateQ == dcachePkg::Idle) && req_i.valid;
  assign inLookup = (stateQ == dcachePkg::Lookup);

  // request payload held for the whole miss path
  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ <= req_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= dcachePkg::Idle;
    end else begin
      stateQ <= stateD;
    end
  end

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      dcachePkg::Idle: begin
        if (req_i.valid) begin
          stateD = dcachePkg::Lookup;
        end
      end
      dcachePkg::Lookup: begin
        if (hit_i) begin
          stateD = dcachePkg::Idle;
        end else if (victimDirty_i) begin
          stateD = dcachePkg::WriteBack;
        end else begin
          stateD = dcachePkg::RefillReq;
        end
      end
      dcachePkg::WriteBack: begin
        if (memWrReady_i) begin
          stateD = dcachePkg::RefillReq;
        end
      end
      dcachePkg::RefillReq: begin
        if (memRdReady_i) begin
          stateD = dcachePkg::RefillData;
        end
      end
      dcachePkg::RefillData: begin
        if (lastBeat_i) begin
          stateD = dcachePkg::Replace;
        end
      end
      // retry the lookup, which now hits
      dcachePkg::Replace: stateD = dcachePkg::Lookup;
      default: stateD = dcachePkg::Idle;
    endcase
  end

  // LFSR on x^16 + x^14 + x^13 + x^11 + 1 steps once per lookup
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsrQ   <= 16'hace1;
      victimQ <= 1'b0;
    end else if (inLookup) begin
      lfsrQ <= {lfsrQ[14:0], lfsrQ[15] ^ lfsrQ[13] ^ lfsrQ[12] ^ lfsrQ[10]};
      if (!hit_i) begin
        victimQ <= lfsrQ[0];
      end
    end
  end

  // hit way on a hit, otherwise the victim being chosen or already held
  always_comb begin
    if (inLookup) begin
      way_o = hit_i ? hitWay_i : lfsrQ[0];
    end else begin
      way_o = victimQ;
    end
  end

  assign ready_o   = (stateQ == dcachePkg::Idle);
  assign done_o    = inLookup && hit_i;
  assign storeEn_o = inLookup && hit_i && (reqQ.op == dcachePkg::Store);
  assign fillEn_o  = (stateQ == dcachePkg::Replace);

  assign reqAddr_o.tag   = reqQ.addr[dcachePkg::AddrWidth-1 -: dcachePkg::TagWidth];
  assign reqAddr_o.index = reqQ.addr[dcachePkg::OffsetWidth +: dcachePkg::IndexWidth];
  assign wordSel_o       = reqQ.addr[dcachePkg::OffsetWidth-1 -: $bits(wordSel_o)];
  assign byteOff_o       = reqQ.addr[$bits(byteOff_o)-1:0];
  assign storeData_o     = reqQ.wrData;
  assign storeMask_o     = reqQ.wrMask;

  // memory strobes are levels held until ready
  assign memRdReq_o.valid = (stateQ == dcachePkg::RefillReq);
  assign memRdReq_o.addr  = {reqAddr_o.tag, reqAddr_o.index, {dcachePkg::OffsetWidth{1'b0}}};
  assign memWrValid_o     = (stateQ == dcachePkg::WriteBack);
  assign memWrAddr_o      = {victimTag_i, reqAddr_o.index, {dcachePkg::OffsetWidth{1'b0}}};
  assign refillActive_o   = (stateQ == dcachePkg::RefillData);

endmodule

/* hw/dataCache.sv */
`timescale 1ns/1ps

module dataCache (
  input  logic                   clk,
  input  logic                   rst_n,
  input  dcachePkg::cacheReq_t   req_i,
  output logic                   ready_o,
  output dcachePkg::cacheResp_t  resp_o,
  output dcachePkg::memRdReq_t   memRdReq_o,
  input  logic                   memRdReady_i,
  output dcachePkg::memWrReq_t   memWrReq_o,
  input  logic                   memWrReady_i,
  input  dcachePkg::memRdResp_t  memRdResp_i
);

  dcachePkg::lineAddr_t                      reqAddr;
  logic [$clog2(dcachePkg::BeatsPerLine)-1:0] wordSel;
  logic [$clog2(dcachePkg::MaskWidth)-1:0]    byteOff;
  logic [dcachePkg::WordWidth-1:0]            storeData;
  logic [dcachePkg::MaskWidth-1:0]            storeMask;
  logic                                       storeEn;
  logic                                       fillEn;
  logic                                       way;
  logic                                       hit;
  logic                                       hitWay;
  logic                                       victimDirty;
  logic [dcachePkg::TagWidth-1:0]             victimTag;
  logic                                       lastBeat;
  logic                                       refillActive;
  logic                                       done;
  logic [dcachePkg::AddrWidth-1:0]            memWrAddr;
  logic                                       memWrValid;
  logic [dcachePkg::LineWidth-1:0]            refillLine;
  logic [dcachePkg::LineWidth-1:0]            victimLine;
  logic [dcachePkg::WordWidth-1:0]            rdWord;

  cacheCtrl cacheCtrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .hit_i         (hit),
    .hitWay_i      (hitWay),
    .victimDirty_i (victimDirty),
    .victimTag_i   (victimTag),
    .lastBeat_i    (lastBeat),
    .memRdReady_i  (memRdReady_i),
    .memWrReady_i  (memWrReady_i),
    .ready_o       (ready_o),
    .done_o        (done),
    .reqAddr_o     (reqAddr),
    .wordSel_o     (wordSel),
    .byteOff_o     (byteOff),
    .storeData_o   (storeData),
    .storeMask_o   (storeMask),
    .storeEn_o     (storeEn),
    .fillEn_o      (fillEn),
    .way_o         (way),
    .memRdReq_o    (memRdReq_o),
    .memWrAddr_o   (memWrAddr),
    .memWrValid_o  (memWrValid),
    .refillActive_o(refillActive)
  );

  tagStore tagStore_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .reqAddr_i    (reqAddr),
    .way_i        (way),
    .storeEn_i    (storeEn),
    .fillEn_i     (fillEn),
    .hit_o        (hit),
    .hitWay_o     (hitWay),
    .victimDirty_o(victimDirty),
    .victimTag_o  (victimTag)
  );

  dataStore dataStore_i (
    .clk         (clk),
    .index_i     (reqAddr.index),
    .wordSel_i   (wordSel),
    .byteOff_i   (byteOff),
    .storeData_i (storeData),
    .storeMask_i (storeMask),
    .storeEn_i   (storeEn),
    .fillEn_i    (fillEn),
    .way_i       (way),
    .fillLine_i  (refillLine),
    .rdWord_o    (rdWord),
    .victimLine_o(victimLine)
  );

  refillBuffer refillBuffer_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .refillActive_i(refillActive),
    .beat_i        (memRdResp_i),
    .line_o        (refillLine),
    .lastBeat_o    (lastBeat)
  );

  // read word is only meaningful while done is high
  assign resp_o.done   = done;
  assign resp_o.rdData = rdWord;

  assign memWrReq_o.valid = memWrValid;
  assign memWrReq_o.addr  = memWrAddr;
  assign memWrReq_o.line  = victimLine;

endmodule

/* hw/dataStore.sv */
`timescale 1ns/1ps

module dataStore (
  input  logic                                       clk,
  input  logic [dcachePkg::IndexWidth-1:0]           index_i,
  input  logic [$clog2(dcachePkg::BeatsPerLine)-1:0] wordSel_i,
  input  logic [$clog2(dcachePkg::MaskWidth)-1:0]    byteOff_i,
  input  logic [dcachePkg::WordWidth-1:0]            storeData_i,
  input  logic [dcachePkg::MaskWidth-1:0]            storeMask_i,
  input  logic                                       storeEn_i,
  input  logic                                       fillEn_i,
  input  logic                                       way_i,
  input  logic [dcachePkg::LineWidth-1:0]            fillLine_i,
  output logic [dcachePkg::WordWidth-1:0]            rdWord_o,
  output logic [dcachePkg::LineWidth-1:0]            victimLine_o
);

  logic [dcachePkg::LineWidth-1:0] lineArr [dcachePkg::NumWays][dcachePkg::NumSets];
  logic [dcachePkg::LineWidth-1:0] curLine;
  logic [dcachePkg::WordWidth-1:0] shiftData;
  logic [dcachePkg::MaskWidth-1:0] shiftMask;
  logic [dcachePkg::WordWidth-1:0] bitMask;
  logic [dcachePkg::LineWidth-1:0] lineMask;
  logic [dcachePkg::LineWidth-1:0] lineData;
  logic [dcachePkg::LineWidth-1:0] mergedLine;

  assign curLine = lineArr[way_i][index_i];

  // align word and byte enables to the byte offset
  assign shiftData = storeData_i << {byteOff_i, 3'b000};
  assign shiftMask = storeMask_i << byteOff_i;

  always_comb begin
    for (int b = 0; b < dcachePkg::MaskWidth; b++) begin
      bitMask[b*8 +: 8] = {8{shiftMask[b]}};
    end
  end

  // then place it in the selected word of the line
  assign lineMask = dcachePkg::LineWidth'(bitMask) << (wordSel_i * dcachePkg::WordWidth);
  assign lineData = dcachePkg::LineWidth'(shiftData) << (wordSel_i * dcachePkg::WordWidth);

  assign mergedLine = (curLine & ~lineMask) | (lineData & lineMask);

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      lineArr[way_i][index_i] <= fillLine_i;
    end else if (storeEn_i) begin
      lineArr[way_i][index_i] <= mergedLine;
    end
  end

  // combinational reads
  assign rdWord_o     = curLine[wordSel_i*dcachePkg::WordWidth +: dcachePkg::WordWidth];
  assign victimLine_o = curLine;

endmodule

/* hw/dcachePkg.sv */
package dcachePkg;

  localparam int AddrWidth    = 32;
  localparam int WordWidth    = 64;
  localparam int LineWidth    = 256;
  localparam int BeatsPerLine = 4;
  localparam int NumSets      = 64;
  localparam int NumWays      = 2;

  // address fields from the top are tag, index and offset
  localparam int OffsetWidth  = 5;
  localparam int IndexWidth   = 6;
  localparam int TagWidth     = 21;
  localparam int MaskWidth    = 8;

  typedef enum logic [2:0] {
    Idle,
    Lookup,
    WriteBack,
    RefillReq,
    RefillData,
    Replace
  } cacheState_e;

  typedef enum logic {
    Load,
    Store
  } memOp_e;

  typedef struct packed {
    logic                 valid;
    memOp_e               op;
    logic [AddrWidth-1:0] addr;
    logic [WordWidth-1:0] wrData;
    logic [MaskWidth-1:0] wrMask;
  } cacheReq_t;

  typedef struct packed {
    logic                 done;
    logic [WordWidth-1:0] rdData;
  } cacheResp_t;

  // line-aligned read request
  typedef struct packed {
    logic                 valid;
    logic [AddrWidth-1:0] addr;
  } memRdReq_t;

  typedef struct packed {
    logic                 valid;
    logic [AddrWidth-1:0] addr;
    logic [LineWidth-1:0] line;
  } memWrReq_t;

  // one refill beat
  typedef struct packed {
    logic                 valid;
    logic [WordWidth-1:0] data;
  } memRdResp_t;

  typedef struct packed {
    logic [TagWidth-1:0]   tag;
    logic [IndexWidth-1:0] index;
  } lineAddr_t;

endpackage

/* hw/refillBuffer.sv */
`timescale 1ns/1ps

module refillBuffer (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            refillActive_i,
  input  dcachePkg::memRdResp_t           beat_i,
  output logic [dcachePkg::LineWidth-1:0] line_o,
  output logic                            lastBeat_o
);

  logic [$clog2(dcachePkg::BeatsPerLine)-1:0] beatCnt;
  logic [dcachePkg::LineWidth-1:0]            lineBuf;
  logic                                       beatTaken;

  assign beatTaken = refillActive_i && beat_i.valid;

  // wraps back to zero after the fourth beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (beatTaken) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // lowest beat lands in the lowest word
  always_ff @(posedge clk) begin
    if (beatTaken) begin
      lineBuf[beatCnt*dcachePkg::WordWidth +: dcachePkg::WordWidth] <= beat_i.data;
    end
  end

  assign lastBeat_o = beatTaken && (beatCnt == $bits(beatCnt)'(dcachePkg::BeatsPerLine - 1));
  assign line_o     = lineBuf;

endmodule

/* hw/tagStore.sv */
`timescale 1ns/1ps

module tagStore (
  input  logic                           clk,
  input  logic                           rst_n,
  input  dcachePkg::lineAddr_t           reqAddr_i,
  input  logic                           way_i,
  input  logic                           storeEn_i,
  input  logic                           fillEn_i,
  output logic                           hit_o,
  output logic                           hitWay_o,
  output logic                           victimDirty_o,
  output logic [dcachePkg::TagWidth-1:0] victimTag_o
);

  logic [dcachePkg::TagWidth-1:0] tagArr [dcachePkg::NumWays][dcachePkg::NumSets];
  logic [dcachePkg::NumSets-1:0]  validArr [dcachePkg::NumWays];
  logic [dcachePkg::NumSets-1:0]  dirtyArr [dcachePkg::NumWays];
  logic [dcachePkg::NumWays-1:0]  wayHit;

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagArr[way_i][reqAddr_i.index] <= reqAddr_i.tag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < dcachePkg::NumWays; w++) begin
        validArr[w] <= '0;
        dirtyArr[w] <= '0;
      end
    end else if (fillEn_i) begin
      // fresh line from memory is clean
      validArr[way_i][reqAddr_i.index] <= 1'b1;
      dirtyArr[way_i][reqAddr_i.index] <= 1'b0;
    end else if (storeEn_i) begin
      dirtyArr[way_i][reqAddr_i.index] <= 1'b1;
    end
  end

  // compare both ways against the latched tag
  always_comb begin
    for (int w = 0; w < dcachePkg::NumWays; w++) begin
      wayHit[w] = validArr[w][reqAddr_i.index] &&
                  (tagArr[w][reqAddr_i.index] == reqAddr_i.tag);
    end
  end

  always_comb begin
    hitWay_o = 1'b0;
    for (int w = 0; w < dcachePkg::NumWays; w++) begin
      if (wayHit[w]) begin
        hitWay_o = w[0];
      end
    end
  end

  assign hit_o = |wayHit;

  // victim info for whichever way the controller names
  assign victimDirty_o = dirtyArr[way_i][reqAddr_i.index];
  assign victimTag_o   = tagArr[way_i][reqAddr_i.index];

endmodule

/* list.f */
hw/dcachePkg.sv
hw/refillBuffer.sv
hw/tagStore.sv
hw/dataStore.sv
hw/cacheCtrl.sv
hw/dataCache.sv
tests/memModel.sv
tests/dataCache_props.sv
tests/dataCacheTb.sv

/* tests/dataCacheTb.sv */
`timescale 1ns/1ps

module dataCacheTb;

  localparam int          ClkPeriod = 10;
  localparam int          RowCycles = 200;
  localparam int          WaitLimit = 150;
  localparam int unsigned Seed      = 32'h65fd_17c7;

  // expected outcome of a row
  localparam logic [1:0] ExpAny  = 2'd0;
  localparam logic [1:0] ExpHit  = 2'd1;
  localparam logic [1:0] ExpMiss = 2'd2;

  typedef struct packed {
    dcachePkg::memOp_e               op;
    logic [dcachePkg::AddrWidth-1:0] addr;
    logic [dcachePkg::WordWidth-1:0] data;
    logic [dcachePkg::MaskWidth-1:0] mask;
    logic [1:0]                      outcome;
  } stimRow_t;

  logic                  clk;
  logic                  rst_n;
  dcachePkg::cacheReq_t  req;
  logic                  ready;
  dcachePkg::cacheResp_t resp;
  dcachePkg::memRdReq_t  memRdReq;
  dcachePkg::memWrReq_t  memWrReq;
  logic                  memRdReady;
  logic                  memWrReady;
  dcachePkg::memRdResp_t memRdResp;

  stimRow_t    stimQ[$];
  logic [63:0] shadow [logic [31:0]];
  int          checks = 0;
  int          errors = 0;
  int          rdCount = 0;
  logic [31:0] lastRdAddr;

  dataCache dataCache_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req),
    .ready_o     (ready),
    .resp_o      (resp),
    .memRdReq_o  (memRdReq),
    .memRdReady_i(memRdReady),
    .memWrReq_o  (memWrReq),
    .memWrReady_i(memWrReady),
    .memRdResp_i (memRdResp)
  );

  memModel memModel_i (
    .clk      (clk),
    .rdReq_i  (memRdReq),
    .wrReq_i  (memWrReq),
    .rdReady_o(memRdReady),
    .wrReady_o(memWrReady),
    .rdResp_o (memRdResp)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic void addRow(input dcachePkg::memOp_e op, input logic [31:0] addr,
                                 input logic [63:0] data, input logic [7:0] mask,
                                 input logic [1:0] outcome);
    stimQ.push_back(stimRow_t'{op, addr, data, mask, outcome});
  endfunction

  function automatic void buildTable();
    addRow(dcachePkg::Load,  32'h0000_1000, 64'h0, 8'h00, ExpMiss);
    addRow(dcachePkg::Load,  32'h0000_1018, 64'h0, 8'h00, ExpHit);
    addRow(dcachePkg::Store, 32'h0000_1008, 64'h1122_3344_5566_7788, 8'h0F, ExpHit);
    addRow(dcachePkg::Load,  32'h0000_1008, 64'h0, 8'h00, ExpHit);
    // byte offset 2 moves data and mask up two bytes
    addRow(dcachePkg::Store, 32'h0000_100A, 64'h0000_0000_0000_AABB, 8'h03, ExpHit);
    addRow(dcachePkg::Load,  32'h0000_1008, 64'h0, 8'h00, ExpHit);
    // many tags share index 2 and the first is dirtied by a store miss
    addRow(dcachePkg::Store, 32'h0000_2040, 64'hDEAD_BEEF_0BAD_F00D, 8'hFF, ExpMiss);
    addRow(dcachePkg::Load,  32'h0000_2040, 64'h0, 8'h00, ExpHit);
    addRow(dcachePkg::Load,  32'h0000_4048, 64'h0, 8'h00, ExpMiss);
    addRow(dcachePkg::Load,  32'h0000_6058, 64'h0, 8'h00, ExpMiss);
    addRow(dcachePkg::Store, 32'h0000_4048, 64'hCAFE_0000_0000_0000, 8'hC0, ExpAny);
    addRow(dcachePkg::Load,  32'h0000_2040, 64'h0, 8'h00, ExpAny);
    addRow(dcachePkg::Load,  32'h0000_8040, 64'h0, 8'h00, ExpMiss);
    addRow(dcachePkg::Load,  32'h0000_A050, 64'h0, 8'h00, ExpMiss);
    addRow(dcachePkg::Load,  32'h0000_2040, 64'h0, 8'h00, ExpAny);
    addRow(dcachePkg::Load,  32'h0000_4048, 64'h0, 8'h00, ExpAny);
    addRow(dcachePkg::Load,  32'h0000_6058, 64'h0, 8'h00, ExpAny);
    addRow(dcachePkg::Store, 32'h0000_2050, 64'h0123_4567_89AB_CDEF, 8'h3C, ExpAny);
    addRow(dcachePkg::Load,  32'h0000_C040, 64'h0, 8'h00, ExpMiss);
    addRow(dcachePkg::Load,  32'h0000_E040, 64'h0, 8'h00, ExpMiss);
    addRow(dcachePkg::Load,  32'h0000_2050, 64'h0, 8'h00, ExpAny);
    addRow(dcachePkg::Load,  32'h0000_4040, 64'h0, 8'h00, ExpAny);
    // index 0 evictions push out the dirty first line
    addRow(dcachePkg::Load,  32'h0000_3000, 64'h0, 8'h00, ExpMiss);
    addRow(dcachePkg::Load,  32'h0000_5000, 64'h0, 8'h00, ExpMiss);
    addRow(dcachePkg::Load,  32'h0000_1008, 64'h0, 8'h00, ExpAny);
    addRow(dcachePkg::Load,  32'hFFFF_F7E0, 64'h0, 8'h00, ExpMiss);
    addRow(dcachePkg::Store, 32'hFFFF_F7E8, 64'h5A5A_5A5A_A5A5_A5A5, 8'hFF, ExpHit);
    addRow(dcachePkg::Load,  32'hFFFF_F7E8, 64'h0, 8'h00, ExpHit);
  endfunction

  // unwritten words hold their address on top and its inverse below
  function automatic logic [63:0] shadowWord(input logic [31:0] addr);
    logic [31:0] wordAddr;
    wordAddr = {addr[31:3], 3'b000};
    if (shadow.exists(wordAddr)) begin
      return shadow[wordAddr];
    end
    return {wordAddr, ~wordAddr};
  endfunction

  function automatic void mergeStore(input stimRow_t row);
    logic [31:0] wordAddr;
    logic [63:0] word;
    logic [63:0] shData;
    logic [7:0]  shMask;
    wordAddr = {row.addr[31:3], 3'b000};
    word     = shadowWord(wordAddr);
    shData   = row.data << (8 * row.addr[2:0]);
    shMask   = row.mask << row.addr[2:0];
    for (int b = 0; b < 8; b++) begin
      if (shMask[b]) begin
        word[b*8 +: 8] = shData[b*8 +: 8];
      end
    end
    shadow[wordAddr] = word;
  endfunction

  function automatic void compareValue(input string name, input logic [63:0] expVal,
                                       input logic [63:0] actVal);
    checks++;
    if (actVal !== expVal) begin
      errors++;
      $display("Fail at %0t: %s expected %h, got %h", $time, name, expVal, actVal);
    end
  endfunction

  function automatic void checkWriteBack(input dcachePkg::memWrReq_t wr);
    for (int w = 0; w < dcachePkg::BeatsPerLine; w++) begin
      compareValue($sformatf("memWrReq.line word %0d of %h", w, wr.addr),
                   shadowWord(wr.addr + 32'(w * 8)), wr.line[w*64 +: 64]);
    end
  endfunction

  // handshakes seen here complete at the next rising edge
  always @(negedge clk) begin
    if (rst_n && memRdReq.valid && memRdReady) begin
      rdCount++;
      lastRdAddr = memRdReq.addr;
    end
    if (rst_n && memWrReq.valid && memWrReady) begin
      checkWriteBack(memWrReq);
    end
  end

  task automatic endRun();
    int assertFails;
    assertFails = dataCache_i.dataCacheProps_i.failCnt;
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, assertFails);
    if (errors == 0 && assertFails == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  task automatic checkResult(input stimRow_t row, input int cycles, input int reads);
    if (row.op == dcachePkg::Load) begin
      compareValue("resp.rdData", shadowWord(row.addr), resp.rdData);
    end else begin
      mergeStore(row);
    end
    if (row.outcome == ExpHit) begin
      compareValue("done latency", 64'd1, 64'(cycles));
      compareValue("memory reads", 64'd0, 64'(reads));
    end else if (row.outcome == ExpMiss) begin
      compareValue("memory reads", 64'd1, 64'(reads));
    end
    if (reads > 0) begin
      compareValue("memRdReq.addr", {32'h0, row.addr[31:5], 5'b0}, {32'h0, lastRdAddr});
    end
  endtask

  task automatic runRow(input stimRow_t row);
    int cycles;
    int rdBefore;
    @(posedge clk);
    #1;
    req.valid  = 1'b1;
    req.op     = row.op;
    req.addr   = row.addr;
    req.wrData = row.data;
    req.wrMask = row.mask;
    rdBefore   = rdCount;
    @(negedge clk);
    if (!ready) begin
      errors++;
      $display("Error at %0t: cache not ready for request to %h", $time, row.addr);
    end
    @(posedge clk);
    #1 req.valid = 1'b0;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!resp.done && cycles < WaitLimit);
    if (!resp.done) begin
      errors++;
      $display("Error at %0t: no done within %0d cycles for request to %h",
               $time, WaitLimit, row.addr);
    end else begin
      checkResult(row, cycles, rdCount - rdBefore);
    end
  endtask

  initial begin
    req   = '0;
    rst_n = 1'b0;
    void'($urandom(Seed));
    buildTable();
    repeat (3) begin
      @(posedge clk);
    end
    #1 rst_n = 1'b1;
    @(negedge clk);
    compareValue("ready_o", 64'd1, 64'(ready));
    compareValue("resp_o.done", 64'd0, 64'(resp.done));
    compareValue("memRdReq_o.valid", 64'd0, 64'(memRdReq.valid));
    compareValue("memWrReq_o.valid", 64'd0, 64'(memWrReq.valid));
    foreach (stimQ[i]) begin
      runRow(stimQ[i]);
    end
    endRun();
  end

  // watchdog sized from the table length
  initial begin
    longint limitNs;
    #1;
    limitNs = longint'(stimQ.size()) * RowCycles * ClkPeriod;
    #(limitNs);
    errors++;
    $display("Error at %0t: run did not finish within %0d ns", $time, limitNs);
    endRun();
  end

endmodule

/* tests/dataCache_props.sv */
`timescale 1ns/1ps

module dataCacheProps (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  ready_i,
  input dcachePkg::cacheResp_t resp_i,
  input dcachePkg::memRdReq_t  memRdReq_i,
  input logic                  memRdReady_i,
  input dcachePkg::memWrReq_t  memWrReq_i,
  input logic                  memWrReady_i
);

  // number of failed assertions so far
  int unsigned failCnt = 0;

  doneOnePulse: assert property (@(posedge clk) disable iff (!rst_n)
      resp_i.done |=> !resp_i.done)
    else begin
      failCnt++;
      $error("done high on two consecutive cycles");
    end

  memOneDir: assert property (@(posedge clk) disable iff (!rst_n)
      !(memRdReq_i.valid && memWrReq_i.valid))
    else begin
      failCnt++;
      $error("memory read and write valid high together");
    end

  rdValidHeld: assert property (@(posedge clk) disable iff (!rst_n)
      memRdReq_i.valid && !memRdReady_i |=> memRdReq_i.valid)
    else begin
      failCnt++;
      $error("memory read valid dropped before ready");
    end

  wrValidHeld: assert property (@(posedge clk) disable iff (!rst_n)
      memWrReq_i.valid && !memWrReady_i |=> memWrReq_i.valid)
    else begin
      failCnt++;
      $error("memory write valid dropped before ready");
    end

  readyNotDone: assert property (@(posedge clk) disable iff (!rst_n)
      !(ready_i && resp_i.done))
    else begin
      failCnt++;
      $error("ready and done high together");
    end

endmodule

bind dataCache dataCacheProps dataCacheProps_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .ready_i     (ready_o),
  .resp_i      (resp_o),
  .memRdReq_i  (memRdReq_o),
  .memRdReady_i(memRdReady_i),
  .memWrReq_i  (memWrReq_o),
  .memWrReady_i(memWrReady_i)
);

/* tests/memModel.sv */
`timescale 1ns/1ps

module memModel (
  input  logic                  clk,
  input  dcachePkg::memRdReq_t  rdReq_i,
  input  dcachePkg::memWrReq_t  wrReq_i,
  output logic                  rdReady_o,
  output logic                  wrReady_o,
  output dcachePkg::memRdResp_t rdResp_o
);

  localparam int MaxReadyDelay = 5;
  localparam int MaxBeatGap    = 3;

  logic [dcachePkg::WordWidth-1:0] mem [logic [dcachePkg::AddrWidth-1:0]];

  // untouched words hold their own address on top and its inverse below
  function automatic logic [dcachePkg::WordWidth-1:0] readWord(input logic [31:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return {addr, ~addr};
  endfunction

  task automatic serveWrite();
    logic [dcachePkg::AddrWidth-1:0] lineAddr;
    logic [dcachePkg::LineWidth-1:0] line;
    @(posedge clk);
    repeat ($urandom_range(MaxReadyDelay)) begin
      @(posedge clk);
    end
    #1 wrReady_o = 1'b1;
    @(negedge clk);
    lineAddr = wrReq_i.addr;
    line     = wrReq_i.line;
    @(posedge clk);
    #1 wrReady_o = 1'b0;
    for (int w = 0; w < dcachePkg::BeatsPerLine; w++) begin
      mem[lineAddr + 32'(w * 8)] = line[w*dcachePkg::WordWidth +: dcachePkg::WordWidth];
    end
  endtask

  task automatic serveRead();
    logic [dcachePkg::AddrWidth-1:0] lineAddr;
    @(posedge clk);
    repeat ($urandom_range(MaxReadyDelay)) begin
      @(posedge clk);
    end
    #1 rdReady_o = 1'b1;
    @(negedge clk);
    lineAddr = rdReq_i.addr;
    @(posedge clk);
    #1 rdReady_o = 1'b0;
    // lowest beat first with idle gaps in between
    for (int b = 0; b < dcachePkg::BeatsPerLine; b++) begin
      repeat ($urandom_range(MaxBeatGap)) begin
        @(posedge clk);
        #1;
      end
      rdResp_o.valid = 1'b1;
      rdResp_o.data  = readWord(lineAddr + 32'(b * 8));
      @(posedge clk);
      #1 rdResp_o.valid = 1'b0;
    end
  endtask

  initial begin
    rdReady_o = 1'b0;
    wrReady_o = 1'b0;
    rdResp_o  = '0;
    forever begin
      @(negedge clk);
      if (wrReq_i.valid) begin
        serveWrite();
      end else if (rdReq_i.valid) begin
        serveRead();
      end
    end
  end

endmodule
